/* ravenoc_params.svh */
`ifndef RAVENOC_PARAMS_SVH
`define RAVENOC_PARAMS_SVH

// --------------------------------------------------
// Flit geometry
// --------------------------------------------------

// Full flit, two type bits on top of the payload.
`define FLIT_WIDTH 34

// Payload carried by one flit, one host word.
`define FLIT_DATA_WIDTH 32

// --------------------------------------------------
// Network interface options
// --------------------------------------------------

// Virtual channels on the local port.
`define NUM_VC 2

// Packet size field, counted in flits.
`define PKT_WIDTH 8

// Size goes into bits 31..24 of the head flit when set to 1.
`define AUTO_ADD_PKT_SZ 1

// Entries per VC in the receive buffer.
`define RX_FIFO_DEPTH 4

`endif

/* ravenoc_flit_pkg.sv */
`default_nettype none

`include "ravenoc_params.svh"

package ravenoc_flit_pkg;

  // --------------------------------------------------
  // Flit encoding on the router side
  // --------------------------------------------------

  // Type field, top two bits of every flit.
  typedef enum logic [1:0] {
    HEAD_FLIT = 2'd0, // Opens a packet.
    BODY_FLIT = 2'd1, // Middle of a packet.
    TAIL_FLIT = 2'd2  // Closes a packet.
  } flit_type_t;

  // Whole flit, type plus payload.
  typedef logic [`FLIT_WIDTH-1:0] fdata_t;

  // Payload part only, as seen by the host.
  typedef logic [`FLIT_DATA_WIDTH-1:0] flit_payload_t;

  // Virtual channel number.
  typedef logic [$clog2(`NUM_VC)-1:0] vc_id_t;

  // --------------------------------------------------
  // Router port handshake
  // --------------------------------------------------

  // Flit request, driven by the sender.
  typedef struct packed {
    logic   valid; // Flit present.
    vc_id_t vc_id; // Channel the flit travels on.
    fdata_t fdata; // Type and payload.
  } s_flit_req_t;

  // Flit response, driven by the receiver.
  typedef struct packed {
    logic ready; // Receiver takes the flit this cycle.
  } s_flit_resp_t;

endpackage

`default_nettype wire

/* ni_host_pkg.sv */
`default_nettype none

`include "ravenoc_params.svh"

package ni_host_pkg;
  import ravenoc_flit_pkg::*;

  // Packet length in flits.
  typedef logic [`PKT_WIDTH-1:0] pkt_sz_t;

  // RX buffer bookkeeping.
  typedef logic [$clog2(`RX_FIFO_DEPTH)-1:0] fifo_ptr_t;  // Slot index.
  typedef logic [$clog2(`RX_FIFO_DEPTH+1)-1:0] fifo_cnt_t; // Fill level, 0..depth.

  // --------------------------------------------------
  // Host to NoC direction
  // --------------------------------------------------

  // Word as the host presents it; pkt_sz counts only on the first word.
  typedef struct packed {
    logic          valid;
    vc_id_t        vc_id;
    pkt_sz_t       pkt_sz;
    flit_payload_t data;
  } s_host_tx_t;

  // Word with its packet position, toward the framing block.
  typedef struct packed {
    logic          valid;
    logic          req_new;         // First word of a packet.
    logic          req_last;        // Last word of a packet.
    vc_id_t        vc_id;
    pkt_sz_t       pkt_sz;          // Meaningful with req_new only.
    flit_payload_t flit_data_width; // Payload word.
  } s_pkt_out_req_t;

  typedef struct packed {
    logic ready;
  } s_pkt_out_resp_t;

  // --------------------------------------------------
  // NoC to host direction
  // --------------------------------------------------

  // Stripped flit toward the RX buffer.
  typedef struct packed {
    logic          valid;
    vc_id_t        rq_vc;
    flit_payload_t flit_data_width;
  } s_pkt_in_req_t;

  typedef struct packed {
    logic ready;
  } s_pkt_in_resp_t;

  // TX sequencer states.
  typedef enum logic {
    IDLE,  // Next word opens a packet.
    IN_PKT // Words of a packet still due.
  } tx_state_t;

endpackage

`default_nettype wire

/* pkt_proc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ravenoc_params.svh"

module pkt_proc import ravenoc_flit_pkg::*, ni_host_pkg::*; (
  // Host side, outgoing words.
  input  s_pkt_out_req_t  pkt_out_req_i,
  output s_pkt_out_resp_t pkt_out_resp_o,

  // Router side, outgoing flits.
  output s_flit_req_t     local_send_o,
  input  s_flit_resp_t    local_send_resp_i,

  // Router side, incoming flits.
  input  s_flit_req_t     local_recv_i,
  output s_flit_resp_t    local_recv_resp_o,

  // Host side, incoming payloads.
  output s_pkt_in_req_t   pkt_in_req_o,
  input  s_pkt_in_resp_t  pkt_in_resp_i
);

  // --------------------------------------------------
  // Host word -> typed flit
  // --------------------------------------------------
  always_comb begin : to_noc
    pkt_out_resp_o.ready = local_send_resp_i.ready; // Router ready straight back.
    local_send_o = '0;                               // Idle bus is all zero.

    if (pkt_out_req_i.valid) begin
      // Payload first, the type and size fields overwrite on top.
      local_send_o.fdata[`FLIT_DATA_WIDTH-1:0] = pkt_out_req_i.flit_data_width;

      // Head wins over tail, so a one-word packet is a head flit.
      priority if (pkt_out_req_i.req_new) begin
        local_send_o.fdata[`FLIT_WIDTH-1 -: 2] = HEAD_FLIT;
        if (`AUTO_ADD_PKT_SZ == 1) begin
          // Size rides in the top payload byte.
          local_send_o.fdata[`FLIT_DATA_WIDTH-1 -: `PKT_WIDTH] = pkt_out_req_i.pkt_sz;
        end
      end
      else if (pkt_out_req_i.req_last) begin
        local_send_o.fdata[`FLIT_WIDTH-1 -: 2] = TAIL_FLIT;
      end
      else begin
        local_send_o.fdata[`FLIT_WIDTH-1 -: 2] = BODY_FLIT;
      end

      local_send_o.vc_id = pkt_out_req_i.vc_id; // Same VC on every flit.
      local_send_o.valid = 1'b1;
    end
  end

  // --------------------------------------------------
  // Received flit -> RX buffer
  // --------------------------------------------------
  always_comb begin : from_noc
    pkt_in_req_o.valid = local_recv_i.valid;
    // Type bits dropped, the buffer keeps payload only.
    pkt_in_req_o.flit_data_width = local_recv_i.fdata[`FLIT_DATA_WIDTH-1:0];
    pkt_in_req_o.rq_vc = local_recv_i.vc_id;
    local_recv_resp_o.ready = pkt_in_resp_i.ready; // Full VC stalls the router.
  end

endmodule

`default_nettype wire

/* tx_pkt_seq.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ravenoc_params.svh"

module tx_pkt_seq import ravenoc_flit_pkg::*, ni_host_pkg::*; (
  input  logic           clk_noc_i,
  input  logic           reset_i,
  input  s_host_tx_t     host_tx_i,    // Word from the host.
  input  s_flit_resp_t   tx_accept_i,  // Router ready.
  output s_pkt_out_req_t pkt_out_req_o // Word with position flags.
);

  tx_state_t state_q;   // Position inside the packet.
  tx_state_t state_d;
  pkt_sz_t   remain_q;  // Words still due, current one included.
  pkt_sz_t   remain_d;
  logic      accepted;  // Word taken by the router this cycle.
  logic      one_word;  // Host asks for a single-word packet.

  assign accepted = host_tx_i.valid && tx_accept_i.ready;

  // Sizes 0 and 1 both give a single word.
  assign one_word = (host_tx_i.pkt_sz <= `PKT_WIDTH'(1));

  // --------------------------------------------------
  // Position flags toward the framing block
  // --------------------------------------------------
  always_comb begin
    pkt_out_req_o.valid           = host_tx_i.valid;
    pkt_out_req_o.vc_id           = host_tx_i.vc_id;
    pkt_out_req_o.flit_data_width = host_tx_i.data;

    if (state_q == IDLE) begin
      pkt_out_req_o.req_new  = 1'b1;
      pkt_out_req_o.req_last = one_word;          // Head and tail at once.
      pkt_out_req_o.pkt_sz   = host_tx_i.pkt_sz;  // Only the first word's size counts.
    end
    else begin
      pkt_out_req_o.req_new  = 1'b0;
      pkt_out_req_o.req_last = (remain_q == `PKT_WIDTH'(1));
      pkt_out_req_o.pkt_sz   = '0;                // Ignored after the head.
    end
  end

  // --------------------------------------------------
  // Next state, moves on accepted words only
  // --------------------------------------------------
  always_comb begin
    state_d  = state_q;
    remain_d = remain_q;

    if (accepted) begin
      case (state_q)
        IDLE: begin
          if (!one_word) begin
            state_d  = IN_PKT;
            remain_d = host_tx_i.pkt_sz - `PKT_WIDTH'(1); // Head already gone.
          end
        end
        IN_PKT: begin
          remain_d = remain_q - `PKT_WIDTH'(1);
          if (remain_q == `PKT_WIDTH'(1)) begin
            state_d = IDLE; // Tail sent.
          end
        end
        default: begin
          state_d = IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_noc_i) begin
    if (reset_i) begin
      state_q  <= IDLE; // Next word after reset is a head.
      remain_q <= '0;
    end
    else begin
      state_q  <= state_d;
      remain_q <= remain_d;
    end
  end

endmodule

`default_nettype wire

/* rx_vc_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ravenoc_params.svh"

module rx_vc_buffer import ravenoc_flit_pkg::*, ni_host_pkg::*; (
  input  logic           clk_noc_i,
  input  logic           reset_i,

  // Stripped flits from the framing block.
  input  s_pkt_in_req_t  pkt_in_req_i,
  output s_pkt_in_resp_t pkt_in_resp_o,

  // Host read port.
  input  vc_id_t         rd_vc_i,   // VC to look at.
  input  logic           rd_pop_i,  // Drop the head word.
  output logic           rd_valid_o,
  output flit_payload_t  rd_data_o
);

  // --------------------------------------------------
  // Storage and per-VC bookkeeping
  // --------------------------------------------------
  flit_payload_t mem [`NUM_VC][`RX_FIFO_DEPTH]; // Payload slots, no reset.
  fifo_ptr_t     wr_ptr [`NUM_VC];
  fifo_ptr_t     rd_ptr [`NUM_VC];
  fifo_cnt_t     count [`NUM_VC];
  logic [`NUM_VC-1:0] full;
  logic [`NUM_VC-1:0] wr_en;
  logic [`NUM_VC-1:0] rd_en;

  // Pointer step with wrap, also for depths that are not a power of two.
  function automatic fifo_ptr_t next_ptr(input fifo_ptr_t ptr);
    if (ptr == fifo_ptr_t'(`RX_FIFO_DEPTH-1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_comb begin
    for (int v = 0; v < `NUM_VC; v++) begin
      full[v]  = (count[v] == fifo_cnt_t'(`RX_FIFO_DEPTH));
      // Write only into the VC the flit names.
      wr_en[v] = pkt_in_req_i.valid && !full[v] && (pkt_in_req_i.rq_vc == vc_id_t'(v));
      // Pop only the selected VC, and only if it holds something.
      rd_en[v] = rd_pop_i && (count[v] != '0) && (rd_vc_i == vc_id_t'(v));
    end
  end

  // Ready follows the addressed VC alone.
  assign pkt_in_resp_o.ready = !full[pkt_in_req_i.rq_vc];

  // --------------------------------------------------
  // Host read-out, first word falls through
  // --------------------------------------------------
  assign rd_valid_o = (count[rd_vc_i] != '0);
  assign rd_data_o  = mem[rd_vc_i][rd_ptr[rd_vc_i]];

  // Payload write.
  always_ff @(posedge clk_noc_i) begin
    for (int v = 0; v < `NUM_VC; v++) begin
      if (wr_en[v]) begin
        mem[v][wr_ptr[v]] <= pkt_in_req_i.flit_data_width;
      end
    end
  end

  // Pointers and fill levels.
  always_ff @(posedge clk_noc_i) begin
    if (reset_i) begin
      for (int v = 0; v < `NUM_VC; v++) begin
        wr_ptr[v] <= '0;
        rd_ptr[v] <= '0;
        count[v]  <= '0; // All VCs empty.
      end
    end
    else begin
      for (int v = 0; v < `NUM_VC; v++) begin
        if (wr_en[v]) begin
          wr_ptr[v] <= next_ptr(wr_ptr[v]);
        end
        if (rd_en[v]) begin
          rd_ptr[v] <= next_ptr(rd_ptr[v]);
        end
        case ({wr_en[v], rd_en[v]})
          2'b10:   count[v] <= count[v] + 1'b1;
          2'b01:   count[v] <= count[v] - 1'b1;
          default: count[v] <= count[v]; // Both or neither, level unchanged.
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* noc_ni.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ravenoc_params.svh"

module noc_ni import ravenoc_flit_pkg::*, ni_host_pkg::*; (
  input  logic          clk_noc_i,
  input  logic          reset_i,

  // Host TX words.
  input  s_host_tx_t    host_tx_i,
  output logic          host_tx_ready_o,

  // Flits toward the local router port.
  output s_flit_req_t   noc_out_o,
  input  s_flit_resp_t  noc_out_resp_i,

  // Flits from the local router port.
  input  s_flit_req_t   noc_in_i,
  output s_flit_resp_t  noc_in_resp_o,

  // Host RX read port.
  input  vc_id_t        rx_vc_sel_i,
  input  logic          rx_pop_i,
  output logic          rx_valid_o,
  output flit_payload_t rx_data_o
);

  // --------------------------------------------------
  // Internal paths
  // --------------------------------------------------
  s_pkt_out_req_t  pkt_out_req;  // Sequencer -> framing.
  s_pkt_out_resp_t pkt_out_resp; // Router ready, passed back.
  s_pkt_in_req_t   pkt_in_req;   // Framing -> RX buffer.
  s_pkt_in_resp_t  pkt_in_resp;  // Buffer not-full for the flit's VC.

  assign host_tx_ready_o = pkt_out_resp.ready; // Host stalls with the router.

  // Marks first and last word of each packet.
  tx_pkt_seq i_tx_pkt_seq (
    .clk_noc_i     (clk_noc_i),
    .reset_i       (reset_i),
    .host_tx_i     (host_tx_i),
    .tx_accept_i   (noc_out_resp_i),
    .pkt_out_req_o (pkt_out_req)
  );

  // Framing both ways.
  pkt_proc i_pkt_proc (
    .pkt_out_req_i     (pkt_out_req),
    .pkt_out_resp_o    (pkt_out_resp),
    .local_send_o      (noc_out_o),
    .local_send_resp_i (noc_out_resp_i),
    .local_recv_i      (noc_in_i),
    .local_recv_resp_o (noc_in_resp_o),
    .pkt_in_req_o      (pkt_in_req),
    .pkt_in_resp_i     (pkt_in_resp)
  );

  // One FIFO per VC for received payloads.
  rx_vc_buffer i_rx_vc_buffer (
    .clk_noc_i     (clk_noc_i),
    .reset_i       (reset_i),
    .pkt_in_req_i  (pkt_in_req),
    .pkt_in_resp_o (pkt_in_resp),
    .rd_vc_i       (rx_vc_sel_i),
    .rd_pop_i      (rx_pop_i),
    .rd_valid_o    (rx_valid_o),
    .rd_data_o     (rx_data_o)
  );

endmodule

`default_nettype wire

/* tb_noc_ni.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ravenoc_params.svh"

module tb_noc_ni import ravenoc_flit_pkg::*, ni_host_pkg::*; ();

  localparam int CLK_PERIOD  = 20;
  localparam int NUM_PKTS    = 40; // Random packets after the directed ones.
  localparam int NUM_RX      = 80; // Random flits taken from the router side.
  localparam int WATCHDOG_NS = (NUM_PKTS * 6 * 10 + NUM_RX * 10 + 500) * CLK_PERIOD;

  // One received word and the VC it came on.
  typedef struct packed {
    vc_id_t        vc;
    flit_payload_t data;
  } rx_entry_t;

  logic          clk_noc_i;
  logic          reset_i;
  s_host_tx_t    host_tx;
  logic          host_tx_ready;
  s_flit_req_t   noc_out;
  s_flit_resp_t  noc_out_resp;
  s_flit_req_t   noc_in;
  s_flit_resp_t  noc_in_resp;
  vc_id_t        rx_vc_sel;
  logic          rx_pop;
  logic          rx_valid;
  flit_payload_t rx_data;

  s_host_tx_t  host_q[$];   // Words not yet taken by the DUT.
  s_flit_req_t exp_tx_q[$]; // Flits due on noc_out_o, in order.
  rx_entry_t   rx_model[$]; // Received words, arrival order over all VCs.
  s_flit_req_t last_out;    // noc_out_o one cycle back.
  logic        stalled;     // Last flit offered but not taken.
  logic        tx_hold;     // Host word must stay on the port.
  logic        rx_hold;     // Router flit must stay on the port.
  int          errors;
  int          checks;
  int          tx_flits;
  int          rx_flits;
  int          rx_words;
  int          seed_val;

  noc_ni i_dut (
    .clk_noc_i       (clk_noc_i),
    .reset_i         (reset_i),
    .host_tx_i       (host_tx),
    .host_tx_ready_o (host_tx_ready),
    .noc_out_o       (noc_out),
    .noc_out_resp_i  (noc_out_resp),
    .noc_in_i        (noc_in),
    .noc_in_resp_o   (noc_in_resp),
    .rx_vc_sel_i     (rx_vc_sel),
    .rx_pop_i        (rx_pop),
    .rx_valid_o      (rx_valid),
    .rx_data_o       (rx_data)
  );

  initial begin
    clk_noc_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_noc_i = ~clk_noc_i;
  end

  // --------------------------------------------------
  // Reference models
  // --------------------------------------------------
  task automatic report_error(input string msg);
    errors++;
    $display("FAILED at %0t ns: %s", $time, msg);
  endtask

  // Index of the oldest word for a VC, -1 when that VC is empty.
  function automatic int oldest(input vc_id_t vc);
    for (int i = 0; i < rx_model.size(); i++) begin
      if (rx_model[i].vc == vc) return i;
    end
    return -1;
  endfunction

  function automatic int vc_level(input vc_id_t vc);
    int n;
    n = 0;
    foreach (rx_model[i]) if (rx_model[i].vc == vc) n++;
    return n;
  endfunction

  // Host words of one packet plus the flits they must turn into.
  task automatic queue_packet(input pkt_sz_t sz);
    int            words;
    vc_id_t        vc;
    s_host_tx_t    w;
    s_flit_req_t   f;
    flit_type_t    t;
    flit_payload_t p;
    words = (sz == 0) ? 1 : int'(sz);
    vc    = vc_id_t'($urandom);
    for (int i = 0; i < words; i++) begin
      w.valid  = 1'b1;
      w.vc_id  = vc;
      w.pkt_sz = (i == 0) ? sz : pkt_sz_t'($urandom); // Junk after the first word.
      w.data   = $urandom;
      host_q.push_back(w);
      p = w.data;
      if (i == 0) begin
        t = HEAD_FLIT; // Head even when it is also the last word.
        if (`AUTO_ADD_PKT_SZ == 1) p[31:24] = sz;
      end
      else if (i == words - 1) t = TAIL_FLIT;
      else t = BODY_FLIT;
      f.valid = 1'b1;
      f.vc_id = vc;
      f.fdata = {t, p};
      exp_tx_q.push_back(f);
    end
  endtask

  // --------------------------------------------------
  // Checks, sampled mid-cycle
  // --------------------------------------------------
  task automatic check_tx();
    checks++;
    assert (host_tx_ready == noc_out_resp.ready)
      else report_error("host_tx_ready_o does not follow the router ready");
    assert (noc_out.valid == host_tx.valid) else report_error("noc_out_o valid is wrong");
    if (stalled && host_tx.valid) begin
      assert (noc_out == last_out) else report_error("flit changed while the router stalled");
    end
    if (noc_out.valid) begin
      assert (exp_tx_q.size() > 0) else report_error("a flit left with no word pending");
      if (exp_tx_q.size() > 0) begin
        assert (noc_out.fdata == exp_tx_q[0].fdata && noc_out.vc_id == exp_tx_q[0].vc_id)
          else report_error($sformatf("flit %h vc %0d, expected %h vc %0d", noc_out.fdata,
                                      noc_out.vc_id, exp_tx_q[0].fdata, exp_tx_q[0].vc_id));
      end
    end
  endtask

  task automatic check_rx();
    int idx;
    checks++;
    idx = oldest(rx_vc_sel);
    assert (rx_valid == (idx >= 0))
      else report_error($sformatf("rx_valid_o %b for VC %0d", rx_valid, rx_vc_sel));
    if (idx >= 0) begin
      assert (rx_data == rx_model[idx].data)
        else report_error($sformatf("rx_data_o %h, expected %h", rx_data, rx_model[idx].data));
    end
    assert (noc_in_resp.ready == (vc_level(noc_in.vc_id) < `RX_FIFO_DEPTH))
      else report_error($sformatf("noc_in_resp_o ready wrong for VC %0d", noc_in.vc_id));
  endtask

  // One clock: check at the falling edge, update models at the rising edge.
  task automatic step_cycle();
    logic      tx_acc;
    logic      rx_acc;
    logic      rx_take;
    int        idx;
    rx_entry_t e;
    @(negedge clk_noc_i);
    check_tx();
    check_rx();
    tx_acc   = host_tx.valid && noc_out_resp.ready;
    rx_acc   = noc_in.valid && (vc_level(noc_in.vc_id) < `RX_FIFO_DEPTH);
    idx      = oldest(rx_vc_sel);
    rx_take  = rx_pop && (idx >= 0);
    stalled  = host_tx.valid && !noc_out_resp.ready;
    last_out = noc_out;
    tx_hold  = host_tx.valid && !tx_acc;
    rx_hold  = noc_in.valid && !rx_acc;
    @(posedge clk_noc_i);
    if (tx_acc && host_q.size() > 0) begin
      host_q.delete(0);
      exp_tx_q.delete(0);
      tx_flits++;
    end
    if (reset_i) rx_model.delete(); // Reset empties every VC.
    else begin
      if (rx_take) begin
        rx_model.delete(idx);
        rx_words++;
      end
      if (rx_acc) begin
        e.vc   = noc_in.vc_id;
        e.data = noc_in.fdata[31:0]; // Type bits stripped.
        rx_model.push_back(e);
        rx_flits++;
      end
    end
    #2; // Inputs change shortly after the edge.
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic drive_tx_random();
    if (!tx_hold) begin
      if (host_q.size() > 0 && $urandom % 4 != 0) host_tx = host_q[0];
      else begin
        host_tx       = s_host_tx_t'({$urandom, $urandom});
        host_tx.valid = 1'b0; // Idle gap with junk data.
      end
    end
    noc_out_resp.ready = ($urandom % 10) < 7;
  endtask

  task automatic drive_rx_random();
    if (!rx_hold) begin
      noc_in.valid = ($urandom % 10) < 6;
      noc_in.vc_id = vc_id_t'($urandom);
      noc_in.fdata = {2'($urandom % 3), flit_payload_t'($urandom)};
    end
    rx_vc_sel = vc_id_t'($urandom);
    rx_pop    = 1'($urandom % 2);
  endtask

  task automatic drain_rx();
    noc_in.valid = 1'b0;
    while (rx_model.size() > 0) begin
      rx_vc_sel = rx_model[0].vc;
      rx_pop    = 1'b1;
      step_cycle();
    end
    rx_pop = 1'b0;
  endtask

  // Idle cycle that looks at the ready of one VC.
  task automatic expect_in_ready(input vc_id_t vc, input logic exp);
    noc_in.vc_id = vc;
    @(negedge clk_noc_i);
    assert (noc_in_resp.ready == exp)
      else report_error($sformatf("noc_in_resp_o ready %b on VC %0d", noc_in_resp.ready, vc));
    @(posedge clk_noc_i);
    #2;
  endtask

  initial begin
    seed_val     = $urandom(32'h3368_d470); // Single seeding for the whole run.
    reset_i      = 1'b1;
    host_tx      = '0;
    noc_out_resp = '0;
    noc_in       = '0;
    rx_vc_sel    = '0;
    rx_pop       = 1'b0;
    last_out     = '0;
    stalled      = 1'b0;
    tx_hold      = 1'b0;
    rx_hold      = 1'b0;
    errors       = 0;
    checks       = 0;
    tx_flits     = 0;
    rx_flits     = 0;
    rx_words     = 0;
    @(posedge clk_noc_i);
    #2;
    repeat (7) step_cycle();
    reset_i = 1'b0;
    assert (!noc_out.valid && !rx_valid) else report_error("outputs active after reset");

    // Short packets first, then random sizes 0 to 6.
    queue_packet(0);
    queue_packet(1);
    queue_packet(0);
    queue_packet(3);
    queue_packet(1);
    repeat (NUM_PKTS) queue_packet(pkt_sz_t'($urandom % 7));
    while (host_q.size() > 0 || rx_flits < NUM_RX || tx_hold || rx_hold) begin
      drive_tx_random();
      drive_rx_random();
      step_cycle();
    end
    host_tx.valid = 1'b0;
    drain_rx();

    // ------------------------------------------------
    // Fill VC 0 and watch the back-pressure
    // ------------------------------------------------
    noc_out_resp.ready = 1'b1;
    for (int i = 0; i < `RX_FIFO_DEPTH; i++) begin
      noc_in = '{valid: 1'b1, vc_id: vc_id_t'(0), fdata: {BODY_FLIT, flit_payload_t'($urandom)}};
      step_cycle();
    end
    noc_in.valid = 1'b0;
    expect_in_ready(vc_id_t'(0), 1'b0);
    expect_in_ready(vc_id_t'(1), 1'b1);
    rx_vc_sel = vc_id_t'(0);
    rx_pop    = 1'b1;
    step_cycle();
    rx_pop = 1'b0;
    expect_in_ready(vc_id_t'(0), 1'b1); // One slot free again.
    drain_rx();

    // ------------------------------------------------
    // Reset in the middle of a packet
    // ------------------------------------------------
    queue_packet(5);
    repeat (2) begin
      host_tx = host_q[0];
      step_cycle();
    end
    host_tx.valid = 1'b0;
    rx_vc_sel     = vc_id_t'(1); // Watch the VC that holds a word across reset.
    noc_in = '{valid: 1'b1, vc_id: vc_id_t'(1), fdata: {HEAD_FLIT, flit_payload_t'($urandom)}};
    step_cycle();
    noc_in.valid = 1'b0;
    reset_i      = 1'b1;
    repeat (2) step_cycle();
    reset_i = 1'b0;
    host_q.delete();
    exp_tx_q.delete();
    queue_packet(3); // Must open with a head flit.
    while (host_q.size() > 0) begin
      host_tx = host_q[0];
      step_cycle();
    end
    host_tx.valid = 1'b0;
    step_cycle();

    $display("TX flits %0d, RX flits %0d, RX words %0d, checks %0d, errors %0d",
             tx_flits, rx_flits, rx_words, checks, errors);
    if (errors == 0) $display("Simulation passed");
    else $display("Simulation failed");
    $finish;
  end

  // Ends a run that hangs.
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: run did not end within %0d ns, TX flits %0d, RX flits %0d, errors %0d",
             WATCHDOG_NS, tx_flits, rx_flits, errors);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* ravenoc_ni.f */
+incdir+.
ravenoc_flit_pkg.sv
ni_host_pkg.sv
pkt_proc.sv
tx_pkt_seq.sv
rx_vc_buffer.sv
noc_ni.sv
tb_noc_ni.sv

/* Bender.yml */
package:
  name: ravenoc_ni

sources:
  - include_dirs:
      - .
    files:
      - ravenoc_flit_pkg.sv
      - ni_host_pkg.sv
      - pkt_proc.sv
      - tx_pkt_seq.sv
      - rx_vc_buffer.sv
      - noc_ni.sv

  - target: test
    include_dirs:
      - .
    files:
      - tb_noc_ni.sv
